// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_opnd_decode
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== src/decode_fifo.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module decode_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  opnd_pkg::decode_req_t push_data,
  input  logic                  pop,
  output opnd_pkg::decode_req_t pop_data,
  output logic                  full,
  output logic                  empty
);

  localparam int ptr_bits = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int cnt_bits = $clog2(`FIFO_DEPTH + 1);
  localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(`FIFO_DEPTH - 1);

  opnd_pkg::decode_req_t mem [`FIFO_DEPTH];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [cnt_bits-1:0]   count;

  // Storage, written at the write pointer
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at the last slot, depth need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy moves only when one side acts alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is visible the cycle after its push
  assign pop_data = mem[rd_ptr];
  assign full     = (count == cnt_bits'(`FIFO_DEPTH));
  assign empty    = (count == '0);

  // Both neighbours must honour the flags
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);
  no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

// ==== src/decode_opnd_signals.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module decode_opnd_signals (
  input  logic [`INSTR_BITS-1:0] unescaped_instr,
  input  opnd_pkg::opnd_form_e   opnd_form,
  input  logic                   prefix_address_16bit,
  // Operand size changes only the immediate width, which is not decoded here
  input  logic                   prefix_operand_16bit,
  output logic                   has_imm,
  output logic                   has_modrm,
  output logic                   has_sib,
  output logic                   has_disp,
  output logic                   is_disp8,
  output logic                   is_disp32,
  output logic [7:0]             modrm,
  output logic [7:0]             sib,
  output logic [31:0]            disp,
  output logic                   modrm_rm_is_reg_direct,
  output logic                   opnd0_modrm_rm,
  output logic                   opnd0_modrm_reg,
  output logic                   opnd0_disp,
  output logic                   opnd1_modrm_rm,
  output logic                   opnd1_modrm_reg,
  output logic                   opnd1_disp
);

  logic [15:0] form_1hot;
  logic        disp_only_modrm;
  logic        form_disp;
  logic [31:0] disp_raw;

  assign form_1hot = 16'd1 << opnd_form;
  assign form_disp = form_1hot[opnd_pkg::disp8] || form_1hot[opnd_pkg::disp32];

  // Forms carrying immediate bytes
  assign has_imm = form_1hot[opnd_pkg::imm]
                || form_1hot[opnd_pkg::modrm_rm_imm]
                || form_1hot[opnd_pkg::reg_imm]
                || form_1hot[opnd_pkg::eax_imm]
                || form_1hot[opnd_pkg::modrm_reg_rm_imm]
                || form_1hot[opnd_pkg::modrm_rm_reg_imm];

  // R/M is the destination, direction bit clear
  assign opnd0_modrm_rm = form_1hot[opnd_pkg::modrm_rm]
                       || form_1hot[opnd_pkg::modrm_rm_imm]
                       || form_1hot[opnd_pkg::modrm_rm_reg]
                       || form_1hot[opnd_pkg::modrm_rm_reg_imm]
                       || form_1hot[opnd_pkg::modrm_rm_reg_cl];

  // REG is the destination, direction bit set
  assign opnd0_modrm_reg = form_1hot[opnd_pkg::modrm_reg_rm]
                        || form_1hot[opnd_pkg::modrm_reg_rm_imm];

  assign opnd1_modrm_rm  = opnd0_modrm_reg;
  assign opnd1_modrm_reg = form_1hot[opnd_pkg::modrm_rm_reg]
                        || form_1hot[opnd_pkg::modrm_rm_reg_imm]
                        || form_1hot[opnd_pkg::modrm_rm_reg_cl];

  assign has_modrm = opnd0_modrm_rm || opnd0_modrm_reg;

  // ModR/M sits right after the opcode
  assign modrm                  = unescaped_instr[15:8];
  assign modrm_rm_is_reg_direct = (modrm[7:6] == 2'b11);

  // SIB only with 32-bit addressing, a memory operand and rm 100
  assign has_sib = has_modrm
                && !prefix_address_16bit
                && !modrm_rm_is_reg_direct
                && (modrm[2:0] == 3'b100);
  assign sib = unescaped_instr[23:16];

  // Mod 00 with rm 101 means disp32 and no base register
  assign disp_only_modrm = (modrm[7:6] == 2'b00) && (modrm[2:0] == 3'b101);

  assign has_disp = (has_modrm
                     && (disp_only_modrm || modrm[7:6] == 2'b01 || modrm[7:6] == 2'b10))
                 || form_disp;

  // Width follows mod, or the form when there is no ModR/M
  assign is_disp8  = has_disp
                  && (form_1hot[opnd_pkg::disp8]
                      || (has_modrm && modrm[7:6] == 2'b01));
  assign is_disp32 = has_disp
                  && (form_1hot[opnd_pkg::disp32]
                      || (has_modrm && (disp_only_modrm || modrm[7:6] == 2'b10)));

  // Displacement starts after opcode, ModR/M and SIB, whichever are there
  always_comb begin
    case ({has_modrm, has_sib})
      2'b11:   disp_raw = unescaped_instr[55:24];
      2'b10:   disp_raw = unescaped_instr[47:16];
      default: disp_raw = unescaped_instr[39:8];
    endcase
  end

  assign disp = !has_disp ? 32'd0
              : is_disp8  ? {{24{disp_raw[7]}}, disp_raw[7:0]}
              : disp_raw;

  // Jump targets belong to operand 0, otherwise the operand holding R/M
  assign opnd0_disp = form_disp || (has_disp && opnd0_modrm_rm);
  assign opnd1_disp = has_disp && opnd1_modrm_rm;

endmodule

// ==== src/decode_result_writer.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module decode_result_writer (
  input  logic                     clk,
  input  logic                     rst_n,
  // FIFO read side
  input  logic                     empty,
  input  opnd_pkg::decode_req_t    pop_data,
  output logic                     pop,
  // Wishbone classic master, write only
  output logic                     m_cyc,
  output logic                     m_stb,
  output logic                     m_we,
  output logic [`SEQ_BITS-1:0]     m_adr,
  output opnd_pkg::decode_result_t m_dat,
  input  logic                     m_ack
);

  localparam logic st_idle  = 1'b0;
  localparam logic st_write = 1'b1;

  logic                     state;
  logic [`SEQ_BITS-1:0]     seq;
  opnd_pkg::decode_result_t record;

  logic        has_imm;
  logic        has_modrm;
  logic        has_sib;
  logic        has_disp;
  logic        is_disp8;
  logic        is_disp32;
  logic [7:0]  modrm;
  logic [7:0]  sib;
  logic [31:0] disp;
  logic        reg_direct;
  logic        opnd0_modrm_rm;
  logic        opnd0_modrm_reg;
  logic        opnd0_disp;
  logic        opnd1_modrm_rm;
  logic        opnd1_modrm_reg;

  // Decodes the FIFO head, which is only taken when idle
  decode_opnd_signals decode_opnd_signals_i (
    .unescaped_instr        (pop_data.instr),
    .opnd_form              (pop_data.form),
    .prefix_address_16bit   (pop_data.addr16),
    .prefix_operand_16bit   (pop_data.oper16),
    .has_imm                (has_imm),
    .has_modrm              (has_modrm),
    .has_sib                (has_sib),
    .has_disp               (has_disp),
    .is_disp8               (is_disp8),
    .is_disp32              (is_disp32),
    .modrm                  (modrm),
    .sib                    (sib),
    .disp                   (disp),
    .modrm_rm_is_reg_direct (reg_direct),
    .opnd0_modrm_rm         (opnd0_modrm_rm),
    .opnd0_modrm_reg        (opnd0_modrm_reg),
    .opnd0_disp             (opnd0_disp),
    .opnd1_modrm_rm         (opnd1_modrm_rm),
    .opnd1_modrm_reg        (opnd1_modrm_reg),
    .opnd1_disp             ()
  );

  // Record packing
  // ModR/M, SIB and the direct flag read as zero when those bytes are absent
  always_comb begin
    record.has_imm          = has_imm;
    record.has_modrm        = has_modrm;
    record.has_sib          = has_sib;
    record.has_disp         = has_disp;
    record.is_disp8         = is_disp8;
    record.is_disp32        = is_disp32;
    record.rm_is_reg_direct = has_modrm && reg_direct;
    record.opnd0_modrm_rm   = opnd0_modrm_rm;
    record.opnd0_modrm_reg  = opnd0_modrm_reg;
    record.opnd0_disp       = opnd0_disp;
    record.opnd1_modrm_rm   = opnd1_modrm_rm;
    record.opnd1_modrm_reg  = opnd1_modrm_reg;
    record.form             = pop_data.form;
    record.modrm            = has_modrm ? modrm : 8'd0;
    record.sib              = has_sib ? sib : 8'd0;
    record.disp             = disp;
  end

  assign pop = (state == st_idle) && !empty;

  // Idle pops one entry, write holds the bus until the slave acks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      seq   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            state <= st_write;
          end
        end
        default: begin
          if (m_ack) begin
            state <= st_idle;
            seq   <= seq + 1'b1;
          end
        end
      endcase
    end
  end

  // Record latched with the pop and held through the write
  always_ff @(posedge clk) begin
    if (pop) begin
      m_dat <= record;
    end
  end

  // Bus drops for the idle cycle after each ack
  assign m_cyc = (state == st_write);
  assign m_stb = m_cyc;
  assign m_we  = m_cyc;
  assign m_adr = seq;

  // Slave may stall any number of cycles with the cycle left unchanged
  bus_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    m_stb && !m_ack |=> m_stb && $stable(m_dat) && $stable(m_adr));

endmodule

// ==== src/instr_form_lookup.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module instr_form_lookup (
  input  logic                      clk,
  input  logic                      rst_n,
  // Wishbone classic slave, write only
  input  logic                      s_cyc,
  input  logic                      s_stb,
  input  logic                      s_we,
  input  logic [`REQ_DAT_BITS-1:0]  s_dat,
  output logic                      s_ack,
  // FIFO write side
  input  logic                      full,
  output logic                      push,
  output opnd_pkg::decode_req_t     push_data
);

  logic [7:0]           opcode;
  opnd_pkg::opnd_form_e form;
  logic                 accept;

  assign opcode = s_dat[7:0];

  // One-byte opcode table, anything unlisted has no operand form
  always_comb begin
    casez (opcode)
      8'h00, 8'h01:               form = opnd_pkg::modrm_rm_reg;
      8'h02, 8'h03:               form = opnd_pkg::modrm_reg_rm;
      8'h05:                      form = opnd_pkg::eax_imm;
      8'h69:                      form = opnd_pkg::modrm_reg_rm_imm;
      8'h80, 8'h81, 8'h83, 8'hc7: form = opnd_pkg::modrm_rm_imm;
      // MOV r32, imm32 with the register in the low opcode bits
      8'b1011_1???:               form = opnd_pkg::reg_imm;
      8'hd3:                      form = opnd_pkg::modrm_rm_reg_cl;
      8'heb:                      form = opnd_pkg::disp8;
      8'he9:                      form = opnd_pkg::disp32;
      8'hff:                      form = opnd_pkg::modrm_rm;
      default:                    form = opnd_pkg::none;
    endcase
  end

  // New write with room in the FIFO
  // The cycle already being acked is not taken a second time
  assign accept = s_cyc && s_stb && s_we && !s_ack && !full;

  // Registered ack, high for one cycle per accepted write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_ack <= 1'b0;
    end else begin
      s_ack <= accept;
    end
  end

  // Request captured together with its form at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      push_data.instr  <= s_dat[`INSTR_BITS-1:0];
      push_data.addr16 <= s_dat[`REQ_DAT_BITS-1];
      push_data.oper16 <= s_dat[`REQ_DAT_BITS-2];
      push_data.form   <= form;
    end
  end

  // Entry enters the FIFO on the ack cycle
  assign push = s_ack;

  // Full is sampled a cycle before the push, so the FIFO must not fill in between
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

endmodule

// ==== src/opnd_consts.svh ====
`ifndef OPND_CONSTS_SVH
`define OPND_CONSTS_SVH

// Entries in the request FIFO
`define FIFO_DEPTH 4

// Unescaped instruction window, opcode in byte 0 and ModR/M in byte 1
`define INSTR_BITS 72

// Inbound write data
// Window in the low bits, address-size flag on top, operand-size flag below it
`define REQ_DAT_BITS 74

// Outbound record address, a sequence number that wraps
`define SEQ_BITS 8

`endif

// ==== src/opnd_decode_top.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module opnd_decode_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Host side, Wishbone classic slave
  input  logic                     s_cyc,
  input  logic                     s_stb,
  input  logic                     s_we,
  input  logic [`REQ_DAT_BITS-1:0] s_dat,
  output logic                     s_ack,
  // Record side, Wishbone classic master
  output logic                     m_cyc,
  output logic                     m_stb,
  output logic                     m_we,
  output logic [`SEQ_BITS-1:0]     m_adr,
  output opnd_pkg::decode_result_t m_dat,
  input  logic                     m_ack
);

  logic                  push;
  logic                  full;
  logic                  pop;
  logic                  empty;
  opnd_pkg::decode_req_t push_data;
  opnd_pkg::decode_req_t pop_data;

  // Opcode classification and inbound handshake
  instr_form_lookup instr_form_lookup_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_cyc     (s_cyc),
    .s_stb     (s_stb),
    .s_we      (s_we),
    .s_dat     (s_dat),
    .s_ack     (s_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  // Full withholds the inbound ack
  decode_fifo decode_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  // Decode and ordered record writes
  decode_result_writer decode_result_writer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .m_cyc    (m_cyc),
    .m_stb    (m_stb),
    .m_we     (m_we),
    .m_adr    (m_adr),
    .m_dat    (m_dat),
    .m_ack    (m_ack)
  );

endmodule

// ==== src/opnd_pkg.sv ====
`include "opnd_consts.svh"

package opnd_pkg;

  // Operand encoding form of a one-byte opcode
  typedef enum logic [3:0] {
    none             = 4'd0,
    imm              = 4'd1,
    modrm_rm         = 4'd2,
    modrm_reg_rm     = 4'd3,
    modrm_rm_reg     = 4'd4,
    modrm_rm_imm     = 4'd5,
    reg_imm          = 4'd6,
    eax_imm          = 4'd7,
    modrm_reg_rm_imm = 4'd8,
    modrm_rm_reg_imm = 4'd9,
    modrm_rm_reg_cl  = 4'd10,
    disp8            = 4'd11,
    disp32           = 4'd12
  } opnd_form_e;

  // FIFO entry, the request with its looked-up form
  typedef struct packed {
    logic [`INSTR_BITS-1:0] instr;
    logic                   addr16;
    logic                   oper16;
    opnd_form_e             form;
  } decode_req_t;

  // Decode record written to the outbound slave, 64 bits
  typedef struct packed {
    logic       has_imm;
    logic       has_modrm;
    logic       has_sib;
    logic       has_disp;
    logic       is_disp8;
    logic       is_disp32;
    logic       rm_is_reg_direct;
    logic       opnd0_modrm_rm;
    logic       opnd0_modrm_reg;
    logic       opnd0_disp;
    logic       opnd1_modrm_rm;
    logic       opnd1_modrm_reg;
    opnd_form_e form;
    logic [7:0] modrm;
    logic [7:0] sib;
    // Already sign-extended when the displacement is one byte
    logic [31:0] disp;
  } decode_result_t;

endpackage

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_ns = 100
) (
  output logic clk
);

  // Free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule

// ==== tests/tb_opnd_decode.sv ====
`timescale 1ns/1ns
`include "opnd_consts.svh"

module tb_opnd_decode;

  localparam int drive_delay = 10;
  localparam logic [31:0] rand_seed = 32'h176f9d7f;
  // About 232 requests at no more than 12 cycles each, plus the stall and resets
  localparam int timeout_cycles = 4000;
  // Four FIFO entries plus the one held by the writer
  localparam int in_flight_max = `FIFO_DEPTH + 1;
  // Every opcode of the form table, byte 0 first
  localparam int n_table_ops = 22;
  localparam logic [n_table_ops*8-1:0] table_ops = {
    8'hff, 8'he9, 8'heb, 8'hd3, 8'hbf, 8'hbe, 8'hbd, 8'hbc, 8'hbb, 8'hba, 8'hb9,
    8'hb8, 8'hc7, 8'h83, 8'h81, 8'h80, 8'h69, 8'h05, 8'h03, 8'h02, 8'h01, 8'h00
  };
  // Fill bytes 2 to 8, one with negative low bytes and one with positive
  localparam logic [55:0] pat_a = 56'h394a5b6c7d8e9f;
  localparam logic [55:0] pat_b = 56'hc2b3a415263748;

  logic                     clk;
  logic                     rst_n;
  logic                     s_cyc;
  logic                     s_stb;
  logic                     s_we;
  logic [`REQ_DAT_BITS-1:0] s_dat;
  logic                     s_ack;
  logic                     m_cyc;
  logic                     m_stb;
  logic                     m_we;
  logic [`SEQ_BITS-1:0]     m_adr;
  opnd_pkg::decode_result_t m_dat;
  logic                     m_ack;

  opnd_pkg::decode_result_t exp_q[$];
  string                    name_q[$];
  string                    test_name;
  logic [`SEQ_BITS-1:0]     exp_seq;
  logic                     slave_hold;
  int                       sent_count;
  int                       checked_count;
  int                       cycle_count;

  tb_clock_gen #(.period_ns(100)) tb_clock_gen_i (.clk(clk));

  opnd_decode_top opnd_decode_top_i (
    .clk   (clk),
    .rst_n (rst_n),
    .s_cyc (s_cyc),
    .s_stb (s_stb),
    .s_we  (s_we),
    .s_dat (s_dat),
    .s_ack (s_ack),
    .m_cyc (m_cyc),
    .m_stb (m_stb),
    .m_we  (m_we),
    .m_adr (m_adr),
    .m_dat (m_dat),
    .m_ack (m_ack)
  );

  // Expected record from the opcode table and the operand decode rules
  function automatic opnd_pkg::decode_result_t ref_decode(
    input logic [`INSTR_BITS-1:0] instr,
    input logic                   addr16
  );
    opnd_pkg::decode_result_t r;
    logic [7:0]  op;
    logic [1:0]  md;
    logic [2:0]  rm;
    int unsigned off;
    logic [31:0] raw;
    r  = '0;
    op = instr[7:0];
    md = instr[15:14];
    rm = instr[10:8];
    if (op == 8'h00 || op == 8'h01) r.form = opnd_pkg::modrm_rm_reg;
    else if (op == 8'h02 || op == 8'h03) r.form = opnd_pkg::modrm_reg_rm;
    else if (op == 8'h05) r.form = opnd_pkg::eax_imm;
    else if (op == 8'h69) r.form = opnd_pkg::modrm_reg_rm_imm;
    else if (op == 8'h80 || op == 8'h81 || op == 8'h83 || op == 8'hc7)
      r.form = opnd_pkg::modrm_rm_imm;
    else if (op[7:3] == 5'b10111) r.form = opnd_pkg::reg_imm;
    else if (op == 8'hd3) r.form = opnd_pkg::modrm_rm_reg_cl;
    else if (op == 8'heb) r.form = opnd_pkg::disp8;
    else if (op == 8'he9) r.form = opnd_pkg::disp32;
    else if (op == 8'hff) r.form = opnd_pkg::modrm_rm;
    else r.form = opnd_pkg::none;
    // Operand roles and immediate presence per form
    case (r.form)
      opnd_pkg::modrm_rm, opnd_pkg::modrm_rm_imm: begin
        r.opnd0_modrm_rm = 1'b1;
      end
      opnd_pkg::modrm_reg_rm, opnd_pkg::modrm_reg_rm_imm: begin
        r.opnd0_modrm_reg = 1'b1;
        r.opnd1_modrm_rm  = 1'b1;
      end
      opnd_pkg::modrm_rm_reg, opnd_pkg::modrm_rm_reg_imm, opnd_pkg::modrm_rm_reg_cl: begin
        r.opnd0_modrm_rm  = 1'b1;
        r.opnd1_modrm_reg = 1'b1;
      end
      opnd_pkg::disp8: begin
        r.has_disp = 1'b1;
        r.is_disp8 = 1'b1;
      end
      opnd_pkg::disp32: begin
        r.has_disp  = 1'b1;
        r.is_disp32 = 1'b1;
      end
      default: begin
      end
    endcase
    r.has_imm = (r.form == opnd_pkg::imm) || (r.form == opnd_pkg::modrm_rm_imm)
             || (r.form == opnd_pkg::reg_imm) || (r.form == opnd_pkg::eax_imm)
             || (r.form == opnd_pkg::modrm_reg_rm_imm)
             || (r.form == opnd_pkg::modrm_rm_reg_imm);
    if (r.opnd0_modrm_rm || r.opnd0_modrm_reg) begin
      r.has_modrm        = 1'b1;
      r.modrm            = instr[15:8];
      r.rm_is_reg_direct = (md == 2'd3);
      // No SIB byte in 16-bit addressing or for a register operand
      r.has_sib = !addr16 && (md != 2'd3) && (rm == 3'd4);
      if (r.has_sib) r.sib = instr[23:16];
      if (md == 2'd1) begin
        r.has_disp = 1'b1;
        r.is_disp8 = 1'b1;
      end else if (md == 2'd2 || (md == 2'd0 && rm == 3'd5)) begin
        r.has_disp  = 1'b1;
        r.is_disp32 = 1'b1;
      end
    end
    r.opnd0_disp = (r.form == opnd_pkg::disp8) || (r.form == opnd_pkg::disp32)
                || (r.has_disp && r.opnd0_modrm_rm);
    if (r.has_disp) begin
      // Displacement follows the opcode and whichever of ModR/M and SIB exist
      off   = 1 + (r.has_modrm ? 1 : 0) + (r.has_sib ? 1 : 0);
      raw   = 32'(instr >> (8 * off));
      r.disp = r.is_disp8 ? {{24{raw[7]}}, raw[7:0]} : raw;
    end
    return r;
  endfunction

  function automatic logic [`INSTR_BITS-1:0] build_window(
    input logic [7:0]  op,
    input logic [7:0]  b1,
    input logic [55:0] rest
  );
    return {rest, b1, op};
  endfunction

  function automatic logic [55:0] rand_rest();
    logic [63:0] v;
    v = {$urandom(), $urandom()};
    return v[55:0];
  endfunction

  function automatic logic [7:0] random_table_op();
    int unsigned idx;
    idx = $urandom() % n_table_ops;
    return 8'(table_ops >> (8 * idx));
  endfunction

  task automatic check_result(
    input string                    name,
    input opnd_pkg::decode_result_t exp_v,
    input opnd_pkg::decode_result_t act_v
  );
    if (act_v !== exp_v) begin
      $display("FAILED %s record expected %h actual %h", name, exp_v, act_v);
      $display("TESTBENCH FAILED");
      $fatal(1, "decode record mismatch");
    end
  endtask

  task automatic check_seq(
    input string                name,
    input logic [`SEQ_BITS-1:0] exp_v,
    input logic [`SEQ_BITS-1:0] act_v
  );
    if (act_v !== exp_v) begin
      $display("FAILED %s address expected %h actual %h", name, exp_v, act_v);
      $display("TESTBENCH FAILED");
      $fatal(1, "record address mismatch");
    end
  endtask

  task automatic check_flag(
    input string name,
    input logic  exp_v,
    input logic  act_v
  );
    if (act_v !== exp_v) begin
      $display("FAILED %s expected %b actual %b", name, exp_v, act_v);
      $display("TESTBENCH FAILED");
      $fatal(1, "bus control mismatch");
    end
  endtask

  // One Wishbone write, held until the registered ack is seen
  // Called and returns just after a rising edge
  task automatic send_req(
    input logic [`INSTR_BITS-1:0] instr,
    input logic                   a16,
    input logic                   o16
  );
    s_cyc = 1'b1;
    s_stb = 1'b1;
    s_we  = 1'b1;
    s_dat = {a16, o16, instr};
    @(negedge clk);
    while (!s_ack) @(negedge clk);
    @(posedge clk);
    #drive_delay;
    s_cyc = 1'b0;
    s_stb = 1'b0;
    s_we  = 1'b0;
    sent_count = sent_count + 1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
  endtask

  // Every accepted request has come back as a record
  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic reg_direct_forms();
    logic [2:0] rm;
    logic [7:0] op;
    test_name = "reg_direct";
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        op = (i == 0) ? 8'h00 : (i == 1) ? 8'h02 : 8'h03;
        rm = (j == 0) ? 3'd0 : (j == 1) ? 3'd4 : 3'd5;
        send_req(build_window(op, {2'b11, 3'(j + 2), rm}, pat_a), 1'b0, 1'b0);
      end
    end
    wait_drain();
  endtask

  // Every mod with rm 100 and 101, both fill patterns, both address sizes
  task automatic memory_forms();
    logic [7:0] op;
    logic [2:0] rm;
    test_name = "memory_forms";
    for (int i = 0; i < 2; i++) begin
      for (int md = 0; md < 4; md++) begin
        for (int j = 0; j < 2; j++) begin
          for (int a = 0; a < 2; a++) begin
            op = (i == 0) ? 8'hff : 8'h81;
            rm = (j == 0) ? 3'd4 : 3'd5;
            send_req(build_window(op, {2'(md), 3'(md), rm}, (a == 0) ? pat_a : pat_b),
                     (a == 1), 1'b0);
          end
        end
      end
    end
    wait_drain();
  endtask

  task automatic imm_and_jump_forms();
    test_name = "imm_forms";
    send_req(build_window(8'h05, 8'hc3, pat_a), 1'b0, 1'b0);
    for (int k = 0; k < 8; k++) begin
      send_req(build_window(8'hb8 | 8'(k), 8'h91, pat_b), 1'b0, (k % 2 == 1));
    end
    // SIB with disp8, then disp32 without base
    send_req(build_window(8'h69, 8'h44, pat_a), 1'b0, 1'b0);
    send_req(build_window(8'h69, 8'h05, pat_b), 1'b0, 1'b1);
    send_req(build_window(8'hc7, 8'h80, pat_a), 1'b0, 1'b0);
    send_req(build_window(8'hc7, 8'hc1, pat_b), 1'b0, 1'b0);
    // Jumps, short target of both signs and a near target
    test_name = "disp_forms";
    send_req(build_window(8'heb, 8'h80, pat_a), 1'b0, 1'b0);
    send_req(build_window(8'heb, 8'h7f, pat_b), 1'b0, 1'b0);
    send_req(build_window(8'he9, 8'hfe, pat_a), 1'b0, 1'b0);
    send_req(build_window(8'he9, 8'h10, pat_b), 1'b0, 1'b0);
    wait_drain();
  endtask

  task automatic unlisted_opcodes();
    test_name = "unlisted";
    send_req(build_window(8'h90, 8'h84, pat_a), 1'b0, 1'b0);
    send_req(build_window(8'h0f, 8'h84, pat_b), 1'b0, 1'b0);
    send_req(build_window(8'hcc, 8'h45, pat_a), 1'b1, 1'b1);
    send_req(build_window(8'h40, 8'h05, pat_b), 1'b0, 1'b0);
    wait_drain();
  endtask

  // Back-to-back burst against a stalled slave, addresses restart at 0
  task automatic stalled_burst();
    test_name = "burst_stall";
    apply_reset();
    slave_hold = 1'b1;
    fork
      begin
        for (int k = 0; k < 20; k++) begin
          send_req(build_window(random_table_op(), 8'($urandom()), rand_rest()),
                   1'($urandom()), 1'($urandom()));
        end
      end
      begin
        repeat (30) @(posedge clk);
        if (exp_q.size() != in_flight_max) begin
          $display("Back-pressure broken: %0d requests accepted during the stall, %0d allowed",
                   exp_q.size(), in_flight_max);
          $display("TESTBENCH FAILED");
          $fatal(1, "back-pressure");
        end else begin
          slave_hold = 1'b0;
        end
      end
    join
    wait_drain();
  endtask

  task automatic random_windows();
    test_name = "random";
    for (int k = 0; k < 150; k++) begin
      send_req(build_window(random_table_op(), 8'($urandom()), rand_rest()),
               1'($urandom()), 1'($urandom()));
    end
    wait_drain();
  endtask

  // Expected record taken while the acked data is still on the bus
  // Operand-size flag leaves the record unchanged
  always @(negedge clk) begin
    if (rst_n && s_ack) begin
      exp_q.push_back(ref_decode(s_dat[`INSTR_BITS-1:0], s_dat[`REQ_DAT_BITS-1]));
      name_q.push_back(test_name);
    end
  end

  // Outbound slave, acks after a 0 to 3 cycle wait unless held
  initial begin : slave_model
    int unsigned w;
    m_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && m_cyc && m_stb && m_we) begin
        while (slave_hold) @(posedge clk);
        w = $urandom() % 4;
        repeat (w) @(posedge clk);
        @(posedge clk);
        #drive_delay;
        m_ack = 1'b1;
        @(posedge clk);
        #drive_delay;
        m_ack = 1'b0;
      end
    end
  end

  // Completed writes compared in order against the expected queue
  initial begin : compare_records
    opnd_pkg::decode_result_t exp_r;
    string                    nm;
    logic                     acked;
    exp_seq = '0;
    acked   = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        exp_seq = '0;
        acked   = 1'b0;
        // Both buses idle while in reset
        check_flag("reset s_ack", 1'b0, s_ack);
        check_flag("reset m_cyc", 1'b0, m_cyc);
        check_flag("reset m_stb", 1'b0, m_stb);
      end else begin
        // Master releases the bus for one cycle after each acked write
        if (acked) begin
          check_flag({test_name, " m_cyc after ack"}, 1'b0, m_cyc);
          check_flag({test_name, " m_stb after ack"}, 1'b0, m_stb);
        end
        acked = 1'b0;
        if (m_cyc && m_stb && m_we && m_ack) begin
          if (exp_q.size() == 0) begin
            $display("Record written at address %0d with no request outstanding", m_adr);
            $display("TESTBENCH FAILED");
            $fatal(1, "unexpected record");
          end else begin
            exp_r = exp_q.pop_front();
            nm    = name_q.pop_front();
            check_result(nm, exp_r, m_dat);
            check_seq(nm, exp_seq, m_adr);
            exp_seq       = exp_seq + 8'd1;
            checked_count = checked_count + 1;
            acked         = 1'b1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n         = 1'b0;
    s_cyc         = 1'b0;
    s_stb         = 1'b0;
    s_we          = 1'b0;
    s_dat         = '0;
    slave_hold    = 1'b0;
    test_name     = "reset";
    sent_count    = 0;
    checked_count = 0;
    cycle_count   = 0;
    void'($urandom(rand_seed));
    apply_reset();
    reg_direct_forms();
    memory_forms();
    imm_and_jump_forms();
    unlisted_opcodes();
    stalled_burst();
    random_windows();
    if (checked_count != sent_count) begin
      $display("Record count mismatch: %0d requests sent, %0d records checked",
               sent_count, checked_count);
      $display("TESTBENCH FAILED");
      $fatal(1, "record count mismatch");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/opnd_pkg.sv
src/instr_form_lookup.sv
src/decode_fifo.sv
src/decode_opnd_signals.sv
src/decode_result_writer.sv
src/opnd_decode_top.sv
tests/tb_clock_gen.sv
tests/tb_opnd_decode.sv
